// File: source/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers
`define RV_NREGS 32

// memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

`endif

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011
    } opcode_e;

    // hint from the main decoder to the alu decoder
    typedef enum logic [1:0] {
        aluop_add   = 2'd0,
        aluop_sub   = 2'd1,
        aluop_funct = 2'd2
    } alu_op_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_slt  = 4'd4,
        alu_xor  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_s = 2'd1,
        imm_b = 2'd2
    } imm_sel_e;

endpackage

// File: source/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // where the write-back value comes from
    typedef enum logic {
        res_alu = 1'b0,
        res_mem = 1'b1
    } result_src_e;

    // data memory action carried down the pipe
    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

endpackage

// File: source/controller.sv
`timescale 1ns/1ps

module controller (
    input  logic [6:0]               opcode,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    output logic                     alu_src,
    output rv_pipe_pkg::result_src_e result_src,
    output rv_pipe_pkg::mem_op_e     mem_op,
    output logic                     reg_write,
    output logic                     branch,
    output rv_isa_pkg::alu_ctrl_e    alu_ctrl,
    output rv_isa_pkg::imm_sel_e     imm_sel
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    alu_op_e     alu_op;
    logic [11:0] alu_instr;

    always_comb begin
        alu_src    = 1'b0;
        result_src = res_alu;
        mem_op     = mem_none;
        reg_write  = 1'b0;
        branch     = 1'b0;
        alu_op     = aluop_add;
        imm_sel    = imm_i;
        case (opcode_e'(opcode))
            opc_load: begin
                if (funct3 == 3'b010) begin // lw only
                    reg_write  = 1'b1;
                    alu_src    = 1'b1;
                    result_src = res_mem;
                    mem_op     = mem_load;
                end
            end
            opc_store: begin
                if (funct3 == 3'b010) begin // sw only
                    imm_sel = imm_s;
                    alu_src = 1'b1;
                    mem_op  = mem_store;
                end
            end
            opc_op: begin
                reg_write = 1'b1;
                alu_op    = aluop_funct;
            end
            opc_branch: begin
                imm_sel = imm_b;  // every branch compares as beq
                alu_op  = aluop_sub;
                branch  = 1'b1;
            end
            opc_op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = aluop_funct;
            end
            default: ; // unknown opcode retires as a no-op
        endcase
    end

    assign alu_instr = {alu_op, funct3, funct7};

    always_comb begin
        if (opcode == opc_op_imm && funct3 == 3'b000) begin
            alu_ctrl = alu_add;  // addi, upper imm bits are not funct7
        end else begin
            casez (alu_instr)
                12'b00_???_???????: alu_ctrl = alu_add;
                12'b01_???_???????: alu_ctrl = alu_sub;
                12'b??_000_0100000: alu_ctrl = alu_sub;
                12'b??_000_0000000: alu_ctrl = alu_add;
                12'b??_010_???????: alu_ctrl = alu_slt;
                12'b??_110_???????: alu_ctrl = alu_or;
                12'b??_111_???????: alu_ctrl = alu_and;
                12'b??_100_???????: alu_ctrl = alu_xor;
                12'b??_011_???????: alu_ctrl = alu_sltu;
                12'b??_001_???????: alu_ctrl = alu_sll;
                12'b??_101_00?????: alu_ctrl = alu_srl;
                12'b??_101_01?????: alu_ctrl = alu_sra;
                default:            alu_ctrl = alu_add;
            endcase
        end
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module fetch_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              imem_we,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_addr,
    input  logic [31:0]                       imem_wdata,
    input  logic                              redirect,
    input  logic [`RV_XLEN-1:0]               redirect_pc,
    output logic                              f_valid,
    input  logic                              f_ready,
    output logic [`RV_XLEN-1:0]               f_pc,
    output logic [31:0]                       f_instr
);
    localparam int imem_aw = $clog2(`RV_IMEM_WORDS);

    logic [31:0]         imem [`RV_IMEM_WORDS];
    logic [`RV_XLEN-1:0] pc;  // address of the next fetch
    logic                issue;

    // new fetch when the output slot is free or leaving this cycle
    assign issue = run && (!f_valid || f_ready) && !redirect;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;  // program load
        end
        if (issue) begin
            f_instr <= imem[pc[imem_aw+1:2]];  // registered read
            f_pc    <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            f_valid <= 1'b0;
        end else if (redirect) begin
            pc      <= redirect_pc;  // drop the pending fetch
            f_valid <= 1'b0;
        end else if (issue) begin
            pc      <= pc + `RV_XLEN'(4);
            f_valid <= 1'b1;
        end else if (f_ready) begin
            f_valid <= 1'b0;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module decode_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         f_valid,
    output logic                         f_ready,
    input  logic [`RV_XLEN-1:0]          f_pc,
    input  logic [31:0]                  f_instr,
    output logic                         d_valid,
    input  logic                         d_ready,
    output logic [`RV_XLEN-1:0]          d_pc,
    output logic [`RV_XLEN-1:0]          d_rs1_val,
    output logic [`RV_XLEN-1:0]          d_rs2_val,
    output logic [`RV_XLEN-1:0]          d_imm,
    output logic [$clog2(`RV_NREGS)-1:0] d_rd,
    output logic                         d_reg_write,
    output logic                         d_alu_src,
    output rv_isa_pkg::alu_ctrl_e        d_alu_ctrl,
    output logic                         d_branch,
    output rv_pipe_pkg::result_src_e     d_result_src,
    output rv_pipe_pkg::mem_op_e         d_mem_op,
    input  logic                         redirect,
    input  logic                         wb_en,
    input  logic [$clog2(`RV_NREGS)-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]          wb_data
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`RV_XLEN-1:0]          regs [`RV_NREGS];
    logic [`RV_NREGS-1:0]         pending;  // one outstanding write per register
    logic [$clog2(`RV_NREGS)-1:0] rs1, rs2, rd;
    logic [`RV_XLEN-1:0]          rs1_val, rs2_val, imm;
    logic                         alu_src, reg_write, reg_write_dec, branch;
    result_src_e                  result_src;
    mem_op_e                      mem_op;
    alu_ctrl_e                    alu_ctrl;
    imm_sel_e                     imm_sel;
    logic                         rs1_busy, rs2_busy, rd_busy, hazard, take;

    assign rs1 = f_instr[19:15];
    assign rs2 = f_instr[24:20];
    assign rd  = f_instr[11:7];

    controller u_controller (
        .opcode     (f_instr[6:0]),
        .funct3     (f_instr[14:12]),
        .funct7     (f_instr[31:25]),
        .alu_src    (alu_src),
        .result_src (result_src),
        .mem_op     (mem_op),
        .reg_write  (reg_write),
        .branch     (branch),
        .alu_ctrl   (alu_ctrl),
        .imm_sel    (imm_sel)
    );

    assign reg_write_dec = reg_write && (rd != '0);  // x0 writes are dropped

    always_comb begin
        case (imm_sel)
            imm_s:   imm = {{20{f_instr[31]}}, f_instr[31:25], f_instr[11:7]};
            imm_b:   imm = {{19{f_instr[31]}}, f_instr[31], f_instr[7],
                            f_instr[30:25], f_instr[11:8], 1'b0};
            default: imm = {{20{f_instr[31]}}, f_instr[31:20]};
        endcase
    end

    // same-cycle write-back is bypassed into the read
    assign rs1_val = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    // a register being written back this cycle no longer blocks
    assign rs1_busy = pending[rs1] && !(wb_en && wb_rd == rs1);
    assign rs2_busy = pending[rs2] && !(wb_en && wb_rd == rs2);
    assign rd_busy  = reg_write_dec && pending[rd] && !(wb_en && wb_rd == rd);
    assign hazard   = rs1_busy || rs2_busy || rd_busy;

    assign f_ready = (!d_valid || d_ready) && !hazard;
    assign take    = f_valid && f_ready && !redirect;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (wb_en) pending[wb_rd] <= 1'b0;
            if (redirect && d_valid && d_reg_write) pending[d_rd] <= 1'b0;  // flushed
            if (take && reg_write_dec) pending[rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (redirect) begin
            d_valid <= 1'b0;
        end else if (take) begin
            d_valid <= 1'b1;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            d_pc         <= f_pc;
            d_rs1_val    <= rs1_val;
            d_rs2_val    <= rs2_val;
            d_imm        <= imm;
            d_rd         <= rd;
            d_reg_write  <= reg_write_dec;
            d_alu_src    <= alu_src;
            d_alu_ctrl   <= alu_ctrl;
            d_branch     <= branch;
            d_result_src <= result_src;
            d_mem_op     <= mem_op;
        end
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module execute_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         d_valid,
    output logic                         d_ready,
    input  logic [`RV_XLEN-1:0]          d_pc,
    input  logic [`RV_XLEN-1:0]          d_rs1_val,
    input  logic [`RV_XLEN-1:0]          d_rs2_val,
    input  logic [`RV_XLEN-1:0]          d_imm,
    input  logic [$clog2(`RV_NREGS)-1:0] d_rd,
    input  logic                         d_reg_write,
    input  logic                         d_alu_src,
    input  rv_isa_pkg::alu_ctrl_e        d_alu_ctrl,
    input  logic                         d_branch,
    input  rv_pipe_pkg::result_src_e     d_result_src,
    input  rv_pipe_pkg::mem_op_e         d_mem_op,
    output logic                         e_valid,
    input  logic                         e_ready,
    output logic [`RV_XLEN-1:0]          e_pc,
    output logic [`RV_XLEN-1:0]          e_alu_result,
    output logic [`RV_XLEN-1:0]          e_store_data,
    output logic [$clog2(`RV_NREGS)-1:0] e_rd,
    output logic                         e_reg_write,
    output rv_pipe_pkg::result_src_e     e_result_src,
    output rv_pipe_pkg::mem_op_e         e_mem_op,
    output logic                         redirect,
    output logic [`RV_XLEN-1:0]          redirect_pc
);
    import rv_isa_pkg::*;

    logic [`RV_XLEN-1:0] src_b, alu_y, e_target;
    logic                take, e_taken;

    assign src_b = d_alu_src ? d_imm : d_rs2_val;

    always_comb begin
        case (d_alu_ctrl)
            alu_add:  alu_y = d_rs1_val + src_b;
            alu_sub:  alu_y = d_rs1_val - src_b;
            alu_and:  alu_y = d_rs1_val & src_b;
            alu_or:   alu_y = d_rs1_val | src_b;
            alu_xor:  alu_y = d_rs1_val ^ src_b;
            alu_slt:  alu_y = `RV_XLEN'($signed(d_rs1_val) < $signed(src_b));
            alu_sltu: alu_y = `RV_XLEN'(d_rs1_val < src_b);
            alu_sll:  alu_y = d_rs1_val << src_b[4:0];
            alu_srl:  alu_y = d_rs1_val >> src_b[4:0];
            alu_sra:  alu_y = $signed(d_rs1_val) >>> src_b[4:0];
            default:  alu_y = '0;
        endcase
    end

    assign d_ready = !e_valid || e_ready;
    assign take    = d_valid && d_ready && !redirect;  // younger item is dropped

    // taken branch redirects fetch as it leaves
    assign redirect    = e_valid && e_ready && e_taken;
    assign redirect_pc = e_target;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid <= 1'b0;
        end else if (take) begin
            e_valid <= 1'b1;
        end else if (e_ready) begin
            e_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            e_pc         <= d_pc;
            e_alu_result <= alu_y;
            e_store_data <= d_rs2_val;
            e_rd         <= d_rd;
            e_reg_write  <= d_reg_write;
            e_result_src <= d_result_src;
            e_mem_op     <= d_mem_op;
            e_taken      <= d_branch && (alu_y == '0);  // beq semantics
            e_target     <= d_pc + d_imm;
        end
    end

endmodule

// File: source/memory_stage.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module memory_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         e_valid,
    output logic                         e_ready,
    input  logic [`RV_XLEN-1:0]          e_pc,
    input  logic [`RV_XLEN-1:0]          e_alu_result,
    input  logic [`RV_XLEN-1:0]          e_store_data,
    input  logic [$clog2(`RV_NREGS)-1:0] e_rd,
    input  logic                         e_reg_write,
    input  rv_pipe_pkg::result_src_e     e_result_src,
    input  rv_pipe_pkg::mem_op_e         e_mem_op,
    output logic                         wb_en,
    output logic [$clog2(`RV_NREGS)-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]          wb_data,
    output logic                         retire_valid,
    input  logic                         retire_ready,
    output logic [`RV_XLEN-1:0]          retire_pc,
    output logic [$clog2(`RV_NREGS)-1:0] retire_rd,
    output logic                         retire_we,
    output logic [`RV_XLEN-1:0]          retire_data
);
    import rv_pipe_pkg::*;

    localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [`RV_XLEN-1:0] alu_q, load_q;
    result_src_e         src_q;
    logic [dmem_aw-1:0]  word_addr;
    logic                take;

    assign e_ready   = !retire_valid || retire_ready;
    assign take      = e_valid && e_ready;
    assign word_addr = e_alu_result[dmem_aw+1:2];  // word addressed

    always_ff @(posedge clk) begin
        if (take && e_mem_op == mem_store) begin
            dmem[word_addr] <= e_store_data;
        end
        if (take && e_mem_op == mem_load) begin
            load_q <= dmem[word_addr];  // sync read, lands with the record
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else if (take) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire_pc <= e_pc;
            retire_rd <= e_rd;
            retire_we <= e_reg_write;
            alu_q     <= e_alu_result;
            src_q     <= e_result_src;
        end
    end

    assign retire_data = (src_q == res_mem) ? load_q : alu_q;

    // register file write as the record leaves
    assign wb_en   = retire_valid && retire_ready && retire_we;
    assign wb_rd   = retire_rd;
    assign wb_data = retire_data;

endmodule

// File: source/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module rv_core_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              imem_we,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] imem_addr,
    input  logic [31:0]                       imem_wdata,
    output logic                              retire_valid,
    input  logic                              retire_ready,
    output logic [`RV_XLEN-1:0]               retire_pc,
    output logic [$clog2(`RV_NREGS)-1:0]      retire_rd,
    output logic                              retire_we,
    output logic [`RV_XLEN-1:0]               retire_data
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // fetch to decode
    logic                         f_valid, f_ready;
    logic [`RV_XLEN-1:0]          f_pc;
    logic [31:0]                  f_instr;

    // decode to execute
    logic                         d_valid, d_ready;
    logic [`RV_XLEN-1:0]          d_pc, d_rs1_val, d_rs2_val, d_imm;
    logic [$clog2(`RV_NREGS)-1:0] d_rd;
    logic                         d_reg_write, d_alu_src, d_branch;
    alu_ctrl_e                    d_alu_ctrl;
    result_src_e                  d_result_src;
    mem_op_e                      d_mem_op;

    // execute to memory
    logic                         e_valid, e_ready;
    logic [`RV_XLEN-1:0]          e_pc, e_alu_result, e_store_data;
    logic [$clog2(`RV_NREGS)-1:0] e_rd;
    logic                         e_reg_write;
    result_src_e                  e_result_src;
    mem_op_e                      e_mem_op;

    // redirect and write-back paths
    logic                         redirect;
    logic [`RV_XLEN-1:0]          redirect_pc;
    logic                         wb_en;
    logic [$clog2(`RV_NREGS)-1:0] wb_rd;
    logic [`RV_XLEN-1:0]          wb_data;

    fetch_stage   u_fetch_stage   (.*);
    decode_stage  u_decode_stage  (.*);
    execute_stage u_execute_stage (.*);
    memory_stage  u_memory_stage  (.*);

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_core_macros.svh"

module tb_rv_core;
    localparam int imem_aw     = $clog2(`RV_IMEM_WORDS);
    localparam int max_records = 256;
    localparam int retire_wait = 200;  // cycles allowed between two retires

    logic                         clk;
    logic                         rst_n;
    logic                         run;
    logic                         imem_we;
    logic [imem_aw-1:0]           imem_addr;
    logic [31:0]                  imem_wdata;
    logic                         retire_valid;
    logic                         retire_ready;
    logic [`RV_XLEN-1:0]          retire_pc;
    logic [$clog2(`RV_NREGS)-1:0] retire_rd;
    logic                         retire_we;
    logic [`RV_XLEN-1:0]          retire_data;

    logic [31:0]         prog [`RV_IMEM_WORDS];
    logic [`RV_XLEN-1:0] exp_pc [max_records];
    int                  exp_rd [max_records];
    int                  exp_we [max_records];
    logic [`RV_XLEN-1:0] exp_data [max_records];
    int                  n_prog;
    int                  n_exp;
    integer              seed;

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string what, input int idx,
                               input logic [31:0] got, input logic [31:0] want);
        stop_run($sformatf("FAILED at %0t: retire %0d %s is %h, expected %h",
                           $time, idx, what, got, want));
    endtask

    // '#' starts a comment, 'I' an instruction word, 'R' an expected retire
    task automatic read_cases();
        integer             fd;
        integer             code;
        logic [7:0]         tag;
        logic [31:0]        word;
        reg [8*256-1:0]     rest;
        logic               done;
        fd = $fopen("testbench/rv_core_cases.txt", "r");
        if (fd == 0) stop_run("could not open testbench/rv_core_cases.txt");
        n_prog = 0;
        n_exp  = 0;
        done   = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;  // end of file
            end else if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I" && n_prog < `RV_IMEM_WORDS) begin
                code = $fscanf(fd, "%h", word);
                prog[n_prog] = word;
                n_prog++;
            end else if (tag == "R" && n_exp < max_records) begin
                code = $fscanf(fd, "%h %d %d %h", exp_pc[n_exp], exp_rd[n_exp],
                               exp_we[n_exp], exp_data[n_exp]);
                n_exp++;
            end else begin
                stop_run("the cases file has a bad tag or too many entries");
            end
        end
        $fclose(fd);
        if (n_exp == 0) stop_run("the cases file holds no expected retire records");
    endtask

    // addi x0, x0, addr so that unused words differ by address
    function automatic logic [31:0] fill_word(input int addr);
        return {addr[11:0], 20'h00013};
    endfunction

    task automatic load_program();
        int a;
        for (a = 0; a < `RV_IMEM_WORDS; a++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = a[imem_aw-1:0];
            imem_wdata = (a < n_prog) ? prog[a] : fill_word(a);
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    // random back-pressure until the next transfer, then compare it
    task automatic check_retire(input int idx);
        int   waited;
        logic fired;
        waited = 0;
        fired  = 1'b0;
        while (!fired) begin
            @(negedge clk);
            retire_ready = ($random(seed) & 32'h3) != 0;
            if (retire_valid && retire_ready) begin
                fired = 1'b1;  // transfer at the next rising edge
            end else begin
                waited++;
                if (waited > retire_wait) begin
                    stop_run($sformatf("timeout: retire %0d did not appear within %0d cycles",
                                       idx, retire_wait));
                end
            end
        end
        assert (retire_pc == exp_pc[idx])
            else value_error("pc", idx, retire_pc, exp_pc[idx]);
        assert (retire_we == exp_we[idx][0])
            else value_error("we", idx, 32'(retire_we), 32'(exp_we[idx]));
        if (exp_we[idx] != 0) begin  // rd and data only mean something on a write
            assert (int'(retire_rd) == exp_rd[idx])
                else value_error("rd", idx, 32'(retire_rd), 32'(exp_rd[idx]));
            assert (retire_data == exp_data[idx])
                else value_error("data", idx, retire_data, exp_data[idx]);
        end
    endtask

    initial begin
        int i;
        seed         = 32'h0bad_2363;
        rst_n        = 1'b0;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        retire_ready = 1'b0;
        read_cases();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        load_program();  // ends on a falling edge
        run = 1'b1;
        for (i = 0; i < n_exp; i++) begin
            check_retire(i);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: testbench/rv_core_cases.txt
# I <instruction hex>, loaded from word address 0 upward
# R <pc hex> <rd dec> <we dec> <data hex>, in retire order; rd and data unchecked when we is 0
I 00500093  # addi x1, x0, 5
I ffd00113  # addi x2, x0, -3
I 002081b3  # add  x3, x1, x2
I 40208233  # sub  x4, x1, x2
I 0020f2b3  # and  x5, x1, x2
I 0020e333  # or   x6, x1, x2
I 0020c3b3  # xor  x7, x1, x2
I 00112433  # slt  x8, x2, x1
I 001134b3  # sltu x9, x2, x1
I 00309513  # slli x10, x1, 3
I 40115593  # srai x11, x2, 1
I 01c15613  # srli x12, x2, 28
I 00c096b3  # sll  x13, x1, x12
I 00d68733  # add  x14, x13, x13
I 00170713  # addi x14, x14, 1
I 00e02823  # sw   x14, 16(x0)
I 01002783  # lw   x15, 16(x0)
I 00178833  # add  x16, x15, x1
I 00508663  # beq  x1, x5, +12 taken
I 00100893  # addi x17, x0, 1 skipped
I 00200913  # addi x18, x0, 2 skipped
I 00208463  # beq  x1, x2, +8 not taken
I 00700993  # addi x19, x0, 7
I 00900013  # addi x0, x0, 9
I 01100a33  # add  x20, x0, x17
I 01390ab3  # add  x21, x18, x19
I 0000007f  # unknown opcode
# expected retire stream
R 00000000 1 1 00000005
R 00000004 2 1 fffffffd
R 00000008 3 1 00000002
R 0000000c 4 1 00000008
R 00000010 5 1 00000005
R 00000014 6 1 fffffffd
R 00000018 7 1 fffffff8
R 0000001c 8 1 00000001
R 00000020 9 1 00000000
R 00000024 10 1 00000028
R 00000028 11 1 fffffffe
R 0000002c 12 1 0000000f
R 00000030 13 1 00028000
R 00000034 14 1 00050000
R 00000038 14 1 00050001
R 0000003c 0 0 00000000
R 00000040 15 1 00050001
R 00000044 16 1 00050006
R 00000048 0 0 00000000
R 00000054 0 0 00000000
R 00000058 19 1 00000007
R 0000005c 0 0 00000000
R 00000060 20 1 00000000
R 00000064 21 1 00000007
R 00000068 0 0 00000000

// File: src.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/controller.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/rv_core_top.sv
testbench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/rv_pipe_pkg.sv
      - source/controller.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/rv_core_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_rv_core.sv
